// File: hw/vdp_pkg.sv
/* VGA timing, VRAM and picture-geometry constants for the display processor
   plus the register-field and beam-position bundles shared by all blocks */

package vdp_pkg;

    //****************************************
    // 640x480 VGA timing
    //****************************************
    localparam int unsigned h_active = 640;     // visible pixels per line
    localparam int unsigned h_front  = 16;
    localparam int unsigned h_sync   = 96;      // hsync pulse width in pixels
    localparam int unsigned h_back   = 48;
    localparam int unsigned v_active = 480;     // visible lines per frame
    localparam int unsigned v_front  = 10;
    localparam int unsigned v_sync   = 2;       // vsync pulse width in lines
    localparam int unsigned v_back   = 33;

    localparam int unsigned h_total = h_active + h_front + h_sync + h_back;  // 800
    localparam int unsigned v_total = v_active + v_front + v_sync + v_back;  // 525

    // VRAM is 16 KB, addressed by a 14 bit pointer
    localparam int unsigned vram_size = 16384;
    localparam int unsigned vram_aw   = $clog2(vram_size);

    //****************************************
    // picture geometry
    //****************************************
    // the 256x192 image is doubled to 512x384 and centred in the active area
    localparam int unsigned pic_x0 = 64;        // first column of the picture
    localparam int unsigned pic_y0 = 48;        // first row of the picture
    localparam int unsigned pic_w  = 512;
    localparam int unsigned pic_h  = 384;

    localparam int unsigned render_lat = 16;    // beam position to colour, in pxclk cycles

    // register fields after decode
    typedef struct packed {
        logic [2:0] mode;           // M3 M2 M1, kept but only Graphics I is drawn
        logic       ie;             // frame interrupt enable
        logic       blank;          // 1 means display on
        logic [3:0] name_base;      // name table at name_base * 1024
        logic [7:0] color_base;     // colour table at color_base * 64
        logic [2:0] pattern_base;   // pattern table at pattern_base * 2048
        logic [3:0] fg;             // text colour, used by text mode only
        logic [3:0] bg;             // backdrop colour
    } vdp_cfg_t;

    // beam position and the flags decoded from it
    typedef struct packed {
        logic [9:0] col;
        logic [9:0] row;
        logic       hsync;          // active low
        logic       vsync;          // active low
        logic       vid_active;     // inside the 640x480 area
        logic       bdr_active;     // active area but outside the picture
        logic       pic_active;     // inside the 512x384 picture
        logic       last_pixel;     // final cycle of the frame
    } beam_t;

    // value a beam delay stage takes in reset, syncs idle high
    localparam beam_t beam_idle = '{col: 10'd0, row: 10'd0, hsync: 1'b1, vsync: 1'b1,
                                    vid_active: 1'b0, bdr_active: 1'b0,
                                    pic_active: 1'b0, last_pixel: 1'b0};

endpackage

// File: hw/vdp_cpu_port.sv
/* CPU side of the display processor: control registers and their decode,
   VRAM pointer with read-ahead latch, frame status flag, irq and dout */
`timescale 1ns/1ps

module vdp_cpu_port (
    input  logic                          pxclk,
    input  logic                          arst_n,
    input  logic                          wr_tick,    // single cycle write strobe
    input  logic                          rd_tick,    // single cycle read strobe
    input  logic                          mode,       // 0 VRAM data, 1 control and status
    input  logic [7:0]                    din,
    input  vdp_pkg::beam_t                beam,
    input  logic [7:0]                    cpu_rdata,  // one cycle after cpu_re
    output logic [7:0]                    dout,
    output logic                          irq,
    output vdp_pkg::vdp_cfg_t             cfg,
    output logic [vdp_pkg::vram_aw-1:0]   cpu_addr,
    output logic                          cpu_we,
    output logic [7:0]                    cpu_wdata,
    output logic                          cpu_re
);

    logic [7:0]                  regs [8];      // the eight control registers
    logic                        second_q;      // 1 once the data byte of a pair is in
    logic [7:0]                  data_q;        // first byte of a control pair
    logic [vdp_pkg::vram_aw-1:0] ptr_q;         // VRAM address pointer
    logic                        fetch_q;       // read-ahead request, drives cpu_re
    logic                        fill_q;        // cpu_rdata holds the read-ahead byte
    logic [7:0]                  ahead_q;       // read-ahead latch
    logic                        frame_q;       // status bit 7
    logic                        frame_nx;

    logic ctl_wr;
    logic ctl_rd;
    logic dat_wr;
    logic dat_rd;

    assign ctl_wr = wr_tick & mode;
    assign ctl_rd = rd_tick & mode;
    assign dat_wr = wr_tick & ~mode;
    assign dat_rd = rd_tick & ~mode;

    // field decode, bit numbering follows the 9918 register map
    always_comb begin
        cfg = '{mode:         {regs[1][4], regs[1][3], regs[0][1]},
                ie:           regs[1][5],
                blank:        regs[1][6],
                name_base:    regs[2][3:0],
                color_base:   regs[3],
                pattern_base: regs[4][2:0],
                fg:           regs[7][7:4],
                bg:           regs[7][3:0]};
    end

    //****************************************
    // control pairs and the VRAM pointer
    //****************************************
    always_ff @(posedge pxclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= 8'h00;
            end
            second_q <= 1'b0;
            data_q   <= 8'h00;
            ptr_q    <= '0;
            fetch_q  <= 1'b0;
            fill_q   <= 1'b0;
        end else begin
            fetch_q <= 1'b0;                                // request lasts one cycle
            fill_q  <= fetch_q;                             // memory answers one cycle later
            if (ctl_rd) second_q <= 1'b0;                   // status read restarts the pair
            if (ctl_wr && !second_q) begin
                data_q   <= din;
                second_q <= 1'b1;
            end else if (ctl_wr) begin
                second_q <= 1'b0;
                if (din[7]) begin
                    regs[din[2:0]] <= data_q;               // register write
                end else begin
                    ptr_q   <= {din[5:0], data_q};          // address set
                    fetch_q <= ~din[6];                     // bit 6 clear asks for a read-ahead
                end
            end
            if (dat_wr) ptr_q <= ptr_q + 1'b1;              // wraps at 16 K by width
            if (dat_rd) begin
                ptr_q   <= ptr_q + 1'b1;
                fetch_q <= 1'b1;                            // refill the latch from the new address
            end
        end
    end

    // latch loads two cycles after the request
    always_ff @(posedge pxclk) begin
        if (fill_q) ahead_q <= cpu_rdata;
    end

    // a frame end wins over a status read landing on the same edge
    assign frame_nx = beam.last_pixel | (frame_q & ~ctl_rd);

    always_ff @(posedge pxclk or negedge arst_n) begin
        if (!arst_n) begin
            frame_q <= 1'b0;
            irq     <= 1'b0;
        end else begin
            frame_q <= frame_nx;
            irq     <= frame_nx & cfg.ie;   // follows the flag without a cycle of lag
        end
    end

    assign cpu_addr  = ptr_q;               // writes and refills both use the pointer
    assign cpu_we    = dat_wr;
    assign cpu_wdata = din;
    assign cpu_re    = fetch_q;

    // read data only during the strobe, zero otherwise
    assign dout = !rd_tick ? 8'h00 : (mode ? {frame_q, 7'b0} : ahead_q);

endmodule

// File: hw/vdp_vram.sv
/* 16 KB VRAM with a CPU read/write port and a renderer read port */
`timescale 1ns/1ps

module vdp_vram (
    input  logic                          pxclk,
    // CPU port
    input  logic [vdp_pkg::vram_aw-1:0]   cpu_addr,
    input  logic                          cpu_we,
    input  logic [7:0]                    cpu_wdata,
    input  logic                          cpu_re,
    output logic [7:0]                    cpu_rdata,
    // renderer port
    input  logic [vdp_pkg::vram_aw-1:0]   ren_addr,
    input  logic                          ren_re,
    output logic [7:0]                    ren_rdata
);

    logic [7:0] mem [vdp_pkg::vram_size];   // contents come up undefined

    //****************************************
    // CPU port, write first then read
    //****************************************
    always_ff @(posedge pxclk) begin
        if (cpu_we) begin
            mem[cpu_addr] <= cpu_wdata;
        end
        if (cpu_re) begin
            cpu_rdata <= mem[cpu_addr];     // held until the next read
        end
    end

    // renderer port only reads, so the two ports never contend
    always_ff @(posedge pxclk) begin
        if (ren_re) begin
            ren_rdata <= mem[ren_addr];
        end
    end

    // a CPU write and a renderer read of the same byte on one edge
    // give the renderer the old value, it is redrawn next frame anyway

endmodule

// File: hw/vdp_timing.sv
/* VGA beam generator: column and row counters and the flags decoded from them */
`timescale 1ns/1ps

module vdp_timing (
    input  logic            pxclk,
    input  logic            arst_n,
    output vdp_pkg::beam_t  beam
);

    logic [9:0] col_q;      // 0 .. h_total-1, active pixels first
    logic [9:0] row_q;      // 0 .. v_total-1, active lines first
    logic       col_end;
    logic       row_end;

    assign col_end = (col_q == 10'(vdp_pkg::h_total - 1));
    assign row_end = (row_q == 10'(vdp_pkg::v_total - 1));

    // counters run free from reset
    always_ff @(posedge pxclk or negedge arst_n) begin
        if (!arst_n) begin
            col_q <= '0;
            row_q <= '0;
        end else begin
            col_q <= col_end ? 10'd0 : col_q + 10'd1;
            if (col_end) begin
                row_q <= row_end ? 10'd0 : row_q + 10'd1;   // row steps at line end
            end
        end
    end

    //****************************************
    // beam flags
    //****************************************
    logic h_vis;
    logic v_vis;
    logic h_pic;
    logic v_pic;

    assign h_vis = (col_q < vdp_pkg::h_active);
    assign v_vis = (row_q < vdp_pkg::v_active);
    assign h_pic = (col_q >= vdp_pkg::pic_x0) && (col_q < vdp_pkg::pic_x0 + vdp_pkg::pic_w);
    assign v_pic = (row_q >= vdp_pkg::pic_y0) && (row_q < vdp_pkg::pic_y0 + vdp_pkg::pic_h);

    always_comb begin
        beam.col        = col_q;
        beam.row        = row_q;
        // sync pulses sit after the front porch, low while inside
        beam.hsync      = !((col_q >= vdp_pkg::h_active + vdp_pkg::h_front) &&
                            (col_q <  vdp_pkg::h_active + vdp_pkg::h_front + vdp_pkg::h_sync));
        beam.vsync      = !((row_q >= vdp_pkg::v_active + vdp_pkg::v_front) &&
                            (row_q <  vdp_pkg::v_active + vdp_pkg::v_front + vdp_pkg::v_sync));
        beam.vid_active = h_vis & v_vis;
        beam.pic_active = h_pic & v_pic;
        beam.bdr_active = h_vis & v_vis & ~(h_pic & v_pic);    // frame around the picture
        beam.last_pixel = col_end & row_end;
    end

endmodule

// File: hw/vdp_render.sv
/* Graphics I renderer: per-character fetch of name, pattern and colour bytes,
   pixel shifter, colour select and the beam delay line that keeps sync aligned */
`timescale 1ns/1ps

module vdp_render (
    input  logic                          pxclk,
    input  logic                          arst_n,
    input  vdp_pkg::vdp_cfg_t             cfg,
    input  vdp_pkg::beam_t                beam,
    input  logic [7:0]                    ren_rdata,  // one cycle after ren_re
    output logic [vdp_pkg::vram_aw-1:0]   ren_addr,
    output logic                          ren_re,
    output logic [3:0]                    color,
    output logic                          hsync,
    output logic                          vsync
);

    logic [9:0] pic_x;          // beam column relative to the picture
    logic [9:0] pic_y;          // beam row relative to the picture
    logic [3:0] phase;          // cycle within the 16 cycle character slot
    logic [4:0] chr_x;          // character column 0..31
    logic [7:0] line_y;         // undoubled picture line 0..191

    logic [7:0] name_q;
    logic [7:0] pat_q;
    logic [7:0] attr_q;
    logic [7:0] shift_q;        // pattern bits, msb is the pixel on screen
    logic [7:0] attr_sh_q;      // colour byte that goes with shift_q

    assign pic_x  = beam.col - 10'(vdp_pkg::pic_x0);
    assign pic_y  = beam.row - 10'(vdp_pkg::pic_y0);
    assign phase  = pic_x[3:0];
    assign chr_x  = pic_x[8:4];
    assign line_y = pic_y[8:1];             // every line is drawn twice

    //****************************************
    // one character fetched per slot
    //****************************************
    // phase 0 name, phase 1 pattern row, phase 2 colour byte
    always_comb begin
        ren_re = beam.pic_active && (phase < 4'd3);
        case (phase)
            4'd0:    ren_addr = {cfg.name_base, line_y[7:3], chr_x};
            4'd1:    ren_addr = {cfg.pattern_base, ren_rdata, line_y[2:0]};  // name just read
            default: ren_addr = {cfg.color_base, 1'b0, name_q[7:3]};       // eight names share one byte
        endcase
    end

    // the delayed flags decide whether any of this payload is shown
    always_ff @(posedge pxclk) begin
        if (beam.pic_active) begin
            if (phase == 4'd1) name_q <= ren_rdata;
            if (phase == 4'd2) pat_q  <= ren_rdata;
            if (phase == 4'd3) attr_q <= ren_rdata;
        end
        // load lands one cycle before the character's first pixel leaves
        // and the output register supplies that cycle
        if (phase == 4'd14) begin
            shift_q   <= pat_q;
            attr_sh_q <= attr_q;
        end else if (!phase[0]) begin
            shift_q   <= {shift_q[6:0], 1'b0};  // one bit per two clocks
        end
    end

    //****************************************
    // beam delay line
    //****************************************
    // render_lat-1 stages here and the output register is the last one
    vdp_pkg::beam_t dly [vdp_pkg::render_lat-1];
    vdp_pkg::beam_t late;

    always_ff @(posedge pxclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < vdp_pkg::render_lat - 1; i++) begin
                dly[i] <= vdp_pkg::beam_idle;
            end
        end else begin
            dly[0] <= beam;
            for (int i = 1; i < vdp_pkg::render_lat - 1; i++) begin
                dly[i] <= dly[i-1];
            end
        end
    end

    assign late = dly[vdp_pkg::render_lat-2];

    // colour select
    logic [3:0] nib;
    logic [3:0] color_nx;

    always_comb begin
        nib = shift_q[7] ? attr_sh_q[7:4] : attr_sh_q[3:0];    // set bit takes the high nibble
        if (!cfg.blank) begin
            color_nx = 4'd0;                                    // display off
        end else if (late.bdr_active) begin
            color_nx = cfg.bg;
        end else if (late.pic_active) begin
            color_nx = (nib == 4'd0) ? cfg.bg : nib;            // transparent shows backdrop
        end else begin
            color_nx = 4'd0;                                    // porches and sync
        end
    end

    always_ff @(posedge pxclk or negedge arst_n) begin
        if (!arst_n) begin
            color <= 4'd0;
            hsync <= 1'b1;
            vsync <= 1'b1;
        end else begin
            color <= color_nx;
            hsync <= late.hsync;
            vsync <= late.vsync;
        end
    end

endmodule

// File: hw/vdp_top.sv
/* display processor top level: CPU port, VRAM, beam timing and renderer */
`timescale 1ns/1ps

module vdp_top (
    input  logic       pxclk,      // 25 MHz pixel clock
    input  logic       arst_n,
    input  logic       wr_tick,    // strobes are in the pxclk domain
    input  logic       rd_tick,
    input  logic       mode,       // valid with the strobes
    input  logic [7:0] din,
    output logic [7:0] dout,       // valid during rd_tick, zero otherwise
    output logic       irq,
    output logic [3:0] color,
    output logic       hsync,
    output logic       vsync
);

    vdp_pkg::vdp_cfg_t            cfg;
    vdp_pkg::beam_t               beam;
    logic [vdp_pkg::vram_aw-1:0]  cpu_addr;
    logic                         cpu_we;
    logic [7:0]                   cpu_wdata;
    logic                         cpu_re;
    logic [7:0]                   cpu_rdata;
    logic [vdp_pkg::vram_aw-1:0]  ren_addr;
    logic                         ren_re;
    logic [7:0]                   ren_rdata;

    //****************************************
    // CPU side
    //****************************************
    vdp_cpu_port port0 (
        .pxclk, .arst_n, .wr_tick, .rd_tick, .mode, .din, .beam, .cpu_rdata,
        .dout, .irq, .cfg, .cpu_addr, .cpu_we, .cpu_wdata, .cpu_re
    );

    // two ports, so the CPU never waits for the renderer
    vdp_vram vram0 (
        .pxclk, .cpu_addr, .cpu_we, .cpu_wdata, .cpu_re, .cpu_rdata,
        .ren_addr, .ren_re, .ren_rdata
    );

    //****************************************
    // video side
    //****************************************
    vdp_timing timing0 (
        .pxclk, .arst_n, .beam
    );

    vdp_render render0 (
        .pxclk, .arst_n, .cfg, .beam, .ren_rdata,
        .ren_addr, .ren_re, .color, .hsync, .vsync
    );

endmodule

// File: tests/vdp_checker.sv
/* display processor checker: shadow registers and VRAM, status, dout and irq
   checks, sync pulse widths and per-pixel colour comparison */
`timescale 1ns/1ps

module vdp_checker (
    input  logic       pxclk,
    input  logic       arst_n,
    input  logic       wr_tick,
    input  logic       rd_tick,
    input  logic       mode,
    input  logic [7:0] din,
    input  logic [7:0] dout,
    input  logic       irq,
    input  logic [3:0] color,
    input  logic       hsync,
    input  logic       vsync,
    input  logic       pix_en,      // every located pixel is compared with the picture rule
    output int         errors,
    output int         checks
);

    localparam int unsigned hs_rise  = vdp_pkg::h_active + vdp_pkg::h_front + vdp_pkg::h_sync;
    localparam int unsigned vs_rise  = vdp_pkg::v_active + vdp_pkg::v_front + vdp_pkg::v_sync;
    localparam int unsigned end_col  = vdp_pkg::h_total - 1 - vdp_pkg::render_lat;

    logic [7:0]  vram [vdp_pkg::vram_size];
    logic [7:0]  regs [8];
    logic        toggle;            // data byte of a control pair is in
    logic [7:0]  first;
    logic [13:0] ptr;
    logic [7:0]  ahead;             // model of the read-ahead latch
    logic        flag;              // status bit 7
    logic        exp_irq;
    logic        col_ok;
    logic        row_ok;
    logic        hs_q;
    logic        vs_q;
    int          col;               // output pixel position, from the sync edges
    int          row;
    int          hs_len;
    int          vs_len;
    int          off_run;           // samples since the display went off
    int          err_count = 0;
    int          check_count = 0;

    assign errors = err_count;
    assign checks = check_count;

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            if (err_count <= 50) begin
                $display("mismatch %s: got %0h expected %0h at col %0d row %0d",
                         what, got, exp, col, row);
            end else if (err_count == 51) begin
                $display("too many errors, further ones are only counted");
            end
        end
    endtask

    // Graphics I pixel from the shadow registers and VRAM
    function automatic logic [3:0] expected_pixel(input int c, input int r);
        int         x;
        int         y;
        logic [7:0] name;
        logic [7:0] pat;
        logic [7:0] attr;
        logic [3:0] nib;
        if (!regs[1][6]) return 4'd0;
        if (c >= vdp_pkg::h_active || r >= vdp_pkg::v_active) return 4'd0;
        if (c < vdp_pkg::pic_x0 || c >= vdp_pkg::pic_x0 + vdp_pkg::pic_w ||
            r < vdp_pkg::pic_y0 || r >= vdp_pkg::pic_y0 + vdp_pkg::pic_h) return regs[7][3:0];
        x    = (c - vdp_pkg::pic_x0) / 2;   // undo the pixel doubling
        y    = (r - vdp_pkg::pic_y0) / 2;
        name = vram[int'(regs[2][3:0]) * 1024 + (y / 8) * 32 + x / 8];
        pat  = vram[int'(regs[4][2:0]) * 2048 + int'(name) * 8 + y % 8];
        attr = vram[int'(regs[3]) * 64 + int'(name) / 8];
        nib  = pat[7 - x % 8] ? attr[7:4] : attr[3:0];
        return (nib == 4'd0) ? regs[7][3:0] : nib;     // colour 0 lets the backdrop through
    endfunction

    always @(negedge pxclk) begin
        if (!arst_n) begin
            compare("irq", irq, 0);
            compare("color", color, 0);
            compare("hsync", hsync, 1);
            compare("vsync", vsync, 1);
            for (int i = 0; i < 8; i++) regs[i] = 8'h00;
            toggle  = 1'b0;
            ptr     = '0;
            flag    = 1'b0;
            exp_irq = 1'b0;
            col_ok  = 1'b0;
            row_ok  = 1'b0;
            hs_q    = 1'b1;
            vs_q    = 1'b1;
            hs_len  = 0;
            vs_len  = 0;
            off_run = 0;
        end else begin
            //****************************************
            // position from the sync edges
            //****************************************
            if (hsync && !hs_q) begin
                compare("hsync width", hs_len, vdp_pkg::h_sync);
                col    = hs_rise;
                col_ok = 1'b1;
            end else if (col_ok) begin
                col = (col == vdp_pkg::h_total - 1) ? 0 : col + 1;
                if (col == 0 && row_ok) row = (row == vdp_pkg::v_total - 1) ? 0 : row + 1;
            end
            if (vsync && !vs_q) begin
                compare("vsync width", vs_len, vdp_pkg::v_sync * vdp_pkg::h_total);
                row    = vs_rise;
                row_ok = 1'b1;
            end
            hs_len = hsync ? 0 : hs_len + 1;
            vs_len = vsync ? 0 : vs_len + 1;
            hs_q   = hsync;
            vs_q   = vsync;

            if (pix_en && col_ok && row_ok) compare("color", color, expected_pixel(col, row));
            else if (!pix_en && off_run >= 2) compare("color", color, 0);  // display off
            compare("irq", irq, exp_irq);

            //****************************************
            // reads, frame flag and writes
            //****************************************
            if (!rd_tick) compare("dout", dout, 0);
            if (rd_tick && mode) begin
                compare("dout", dout, {flag, 7'b0});
                toggle = 1'b0;
            end
            if (rd_tick && !mode) begin
                compare("dout", dout, ahead);
                ptr   = ptr + 1'b1;
                ahead = vram[ptr];
            end
            // output leads the beam's last pixel by the render latency
            flag    = (col_ok && row_ok && col == end_col && row == vdp_pkg::v_total - 1) |
                      (flag & ~(rd_tick & mode));
            exp_irq = flag & regs[1][5];
            if (wr_tick && mode && !toggle) begin
                first  = din;
                toggle = 1'b1;
            end else if (wr_tick && mode) begin
                toggle = 1'b0;
                if (din[7]) begin
                    regs[din[2:0]] = first;
                end else begin
                    ptr = {din[5:0], first};
                    if (!din[6]) ahead = vram[ptr];
                end
            end
            if (wr_tick && !mode) begin
                vram[ptr] = din;
                ptr       = ptr + 1'b1;                 // wraps at 16 K
            end
            if (regs[1][6]) off_run = 0;
            else if (off_run < 2) off_run++;
        end
    end

endmodule

// File: tests/tb_vdp.sv
/* display processor testbench top: clock, reset, seeded random CPU traffic,
   watchdog and the closing report */
`timescale 1ns/1ps

module tb_vdp;

    localparam int unsigned gap          = 4;                   // idle cycles after each strobe
    localparam int unsigned n_fill       = vdp_pkg::vram_size;  // whole VRAM is filled once
    localparam int unsigned n_read       = 600;
    localparam int unsigned frame_cycles = vdp_pkg::h_total * vdp_pkg::v_total;
    localparam int unsigned stim_cycles  = 16 + (n_fill + n_read + 64) * (gap + 1);
    localparam int unsigned limit_cycles = stim_cycles + 4 * frame_cycles;

    logic       pxclk;
    logic       arst_n;
    logic       wr_tick;
    logic       rd_tick;
    logic       mode;
    logic [7:0] din;
    logic [7:0] dout;
    logic       irq;
    logic [3:0] color;
    logic       hsync;
    logic       vsync;
    logic       pix_en;         // VRAM and bases are final, so every pixel is compared
    int         errors;
    int         checks;

    vdp_top dut0 (.pxclk, .arst_n, .wr_tick, .rd_tick, .mode, .din,
                  .dout, .irq, .color, .hsync, .vsync);

    vdp_checker checker0 (.pxclk, .arst_n, .wr_tick, .rd_tick, .mode, .din, .dout, .irq,
                          .color, .hsync, .vsync, .pix_en, .errors, .checks);

    initial begin
        pxclk = 1'b0;
        forever #4 pxclk = ~pxclk;                              // 125 MHz sim clock, 8 ns
    end

    //****************************************
    // CPU bus helpers
    //****************************************
    // one strobe cycle then a fixed gap, always entered 1 ns after a rising edge
    task automatic bus_cycle(input logic wr, input logic m, input logic [7:0] d);
        wr_tick = wr;
        rd_tick = ~wr;
        mode    = m;
        din     = d;
        @(posedge pxclk);
        #1;
        wr_tick = 1'b0;
        rd_tick = 1'b0;
        mode    = 1'b0;
        din     = 8'h00;
        repeat (gap) begin
            @(posedge pxclk);
            #1;
        end
    endtask

    task automatic write_reg(input logic [2:0] idx, input logic [7:0] val);
        bus_cycle(1'b1, 1'b1, val);
        bus_cycle(1'b1, 1'b1, {5'b10000, idx});                 // bit 7 set selects a register
    endtask

    // bit 6 of the command byte clear asks for a read-ahead
    task automatic set_address(input logic [13:0] a, input logic for_read);
        bus_cycle(1'b1, 1'b1, a[7:0]);
        bus_cycle(1'b1, 1'b1, {1'b0, ~for_read, a[13:8]});
    endtask

    initial begin
        logic [7:0]  val;
        logic [13:0] start;
        void'($urandom(32'h6a9e_a9ee));
        arst_n  = 1'b0;
        wr_tick = 1'b0;
        rd_tick = 1'b0;
        mode    = 1'b0;
        din     = 8'h00;
        pix_en  = 1'b0;
        repeat (16) @(posedge pxclk);
        #1 arst_n = 1'b1;
        repeat (4) @(posedge pxclk);
        #1;
        bus_cycle(1'b0, 1'b1, 8'h00);                           // first status read after reset
        // phase one with the display off
        for (int i = 0; i < 8; i++) begin
            val = 8'($urandom);
            if (i == 1) val[6] = 1'b0;                          // blank bit stays clear for now
            write_reg(3'(i), val);
        end
        start = 14'($urandom);
        set_address(start, 1'b0);
        repeat (n_fill) bus_cycle(1'b1, 1'b0, 8'($urandom));    // wraps past 16383
        set_address(14'(vdp_pkg::vram_size - n_read / 2), 1'b1);
        repeat (n_read) bus_cycle(1'b0, 1'b0, 8'h00);           // read-back crosses the wrap
        // phase two, display on, then one status read late in each frame
        write_reg(3'd1, 8'($urandom) | 8'h40);
        pix_en = 1'b1;
        for (int k = 0; k < 4; k++) begin
            @(negedge vsync);
            @(posedge pxclk);
            #1;
            bus_cycle(1'b0, 1'b1, 8'h00);
            if ($urandom % 2) bus_cycle(1'b0, 1'b1, 8'h00);     // a second read finds the flag clear
            write_reg(3'd1, 8'($urandom) | 8'h40);              // new random ie for the next frame end
        end
        repeat (64) @(posedge pxclk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // watchdog, the stimulus time plus four frames
    initial begin
        repeat (limit_cycles) @(posedge pxclk);
        $display("timeout, the run did not complete within %0d cycles", limit_cycles);
        $display("checks %0d, errors %0d", checks, errors);
        $display("Testbench failed");
        $finish;
    end

endmodule

// File: sources.f
hw/vdp_pkg.sv
hw/vdp_cpu_port.sv
hw/vdp_vram.sv
hw/vdp_timing.sv
hw/vdp_render.sv
hw/vdp_top.sv
tests/vdp_checker.sv
tests/tb_vdp.sv

// File: run.sh
#!/usr/bin/env bash
# build the display processor testbench with Verilator, run it and judge the log
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_vdp -f sources.f -o sim_vdp \
    && ./obj_dir/sim_vdp 2>&1 | tee sim.log \
    || { echo "build or simulation did not complete"; exit 1; }

grep -q "Testbench failed" sim.log && exit 1
grep -q "Testbench passed" sim.log || exit 1
exit 0
